//--- Bender.yml
package:
  name: pmp_checker

export_include_dirs:
  - hdl

sources:
  - hdl/pmp_pkg.sv
  - hdl/pmp_entry_if.sv
  - hdl/pmp_cfg_regs.sv
  - hdl/pmp_comp_hit.sv
  - hdl/pmp_prio_resolve.sv
  - hdl/pmp_top.sv
  - target: simulation
    files:
      - bench/pmp_checker.sv
      - bench/pmp_tb.sv

//--- bench/pmp_checker.sv
//--------------------------------------------------------------------------
// PMP checker assertions
// Shadow copy of the entry table and an expected response per request,
// compared with every response field through concurrent assertions
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "pmp_consts.svh"

module pmp_checker (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cfg_wr,
  input  pmp_pkg::entry_idx_t  cfg_idx,
  input  pmp_pkg::pmpcfg_t     cfg_data,
  input  pmp_pkg::pmpaddr_t    cfg_addr,
  input  logic                 req_vld,
  input  pmp_pkg::ppn_t        req_ppn,
  input  logic                 req_chk1,
  input  pmp_pkg::acc_type_e   req_acc,
  input  logic                 req_mmode,
  input  logic                 resp_vld,
  input  logic                 resp_fault,
  input  logic                 resp_hit,
  input  pmp_pkg::entry_idx_t  resp_idx,
  input  logic                 resp_cross
);

  pmp_pkg::pmpcfg_t    sh_cfg  [`PMP_ENTRIES];   // Shadow table
  pmp_pkg::pmpaddr_t   sh_addr [`PMP_ENTRIES];
  logic                e_hit, e_fault, e_cross;  // Expected from current inputs
  pmp_pkg::entry_idx_t e_idx;
  logic                x_vld, x_hit, x_fault, x_cross;  // Expected one cycle later
  pmp_pkg::entry_idx_t x_idx;
  int                  err_cnt = 0;              // Failed assertion count

  // Expected response from the match and permission rules
  always_comb
  begin
    pmp_pkg::ppn_t base;
    pmp_pkg::ppn_t bottom;
    pmp_pkg::ppn_t mask;
    logic [1:0]    mode;
    logic          hit_i;
    logic          perm;
    int            t;
    e_hit   = 1'b0;
    e_idx   = '0;
    e_cross = 1'b0;
    e_fault = 1'b0;
    perm    = 1'b0;
    bottom  = '0;
    for (int i = 0; i < `PMP_ENTRIES; i++)
    begin
      base = sh_addr[i][`PMP_ADDR_WIDTH-1:1];
      mode = sh_cfg[i][`PMP_CFG_A_HI:`PMP_CFG_A_LO];
      t = 0;
      while (t < `PMP_ADDR_WIDTH && sh_addr[i][t])
        t++;                                     // Trailing ones
      mask = (t >= `PMP_PPN_WIDTH) ? '0 : (pmp_pkg::ppn_t'('1) << t);
      hit_i = (mode == pmp_pkg::PMP_TOR)   ? (req_ppn >= bottom && req_ppn < base) :
              (mode == pmp_pkg::PMP_NAPOT) ? ((req_ppn & mask) == (base & mask)) : 1'b0;
      if (mode == pmp_pkg::PMP_NAPOT)
        e_cross |= req_chk1 ? (req_ppn < (base | ~mask)) : (req_ppn >= (base & mask));
      if (hit_i && !e_hit)
      begin
        e_hit = 1'b1;
        e_idx = pmp_pkg::entry_idx_t'(i);
        perm  = (req_acc == pmp_pkg::ACC_READ)  ? sh_cfg[i][`PMP_CFG_R] :
                (req_acc == pmp_pkg::ACC_WRITE) ? sh_cfg[i][`PMP_CFG_W] :
                (req_acc == pmp_pkg::ACC_EXEC)  ? sh_cfg[i][`PMP_CFG_X] : 1'b0;
        e_fault = (!req_mmode || sh_cfg[i][`PMP_CFG_L]) && !perm;
      end
      bottom = base;                             // Next entry's TOR bottom
    end
    if (!e_hit)
      e_fault = !req_mmode;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      x_vld <= 1'b0;
      for (int i = 0; i < `PMP_ENTRIES; i++)
      begin
        sh_cfg[i]  <= '0;
        sh_addr[i] <= '0;
      end
    end
    else
    begin
      x_vld <= req_vld;
      if (req_vld)
      begin
        x_hit   <= e_hit;
        x_idx   <= e_idx;
        x_fault <= e_fault;
        x_cross <= e_cross;
      end
      if (cfg_wr && !sh_cfg[cfg_idx][`PMP_CFG_L])  // Locked entries keep state
      begin
        sh_cfg[cfg_idx]  <= cfg_data;
        sh_addr[cfg_idx] <= cfg_addr;
      end
    end
  end

  //------------------------------------------------------------------------
  // Assertions
  //------------------------------------------------------------------------
  a_rst_vld: assert property (@(posedge clk) !rst_n |-> !resp_vld)
    else begin
      $error("FAIL t=%0t resp_vld exp 0 got %0b", $time, $sampled(resp_vld));
      err_cnt++;
    end
  a_vld: assert property (@(posedge clk) disable iff (!rst_n) resp_vld == x_vld)
    else begin
      $error("FAIL t=%0t resp_vld exp %0b got %0b", $time, $sampled(x_vld),
             $sampled(resp_vld));
      err_cnt++;
    end
  a_hit: assert property (@(posedge clk) disable iff (!rst_n) resp_vld |-> resp_hit == x_hit)
    else begin
      $error("FAIL t=%0t resp_hit exp %0b got %0b", $time, $sampled(x_hit),
             $sampled(resp_hit));
      err_cnt++;
    end
  a_idx: assert property (@(posedge clk) disable iff (!rst_n) resp_vld |-> resp_idx == x_idx)
    else begin
      $error("FAIL t=%0t resp_idx exp %0d got %0d", $time, $sampled(x_idx),
             $sampled(resp_idx));
      err_cnt++;
    end
  a_fault: assert property (@(posedge clk) disable iff (!rst_n)
                            resp_vld |-> resp_fault == x_fault)
    else begin
      $error("FAIL t=%0t resp_fault exp %0b got %0b", $time, $sampled(x_fault),
             $sampled(resp_fault));
      err_cnt++;
    end
  a_cross: assert property (@(posedge clk) disable iff (!rst_n)
                            resp_vld |-> resp_cross == x_cross)
    else begin
      $error("FAIL t=%0t resp_cross exp %0b got %0b", $time, $sampled(x_cross),
             $sampled(resp_cross));
      err_cnt++;
    end

endmodule

bind pmp_top pmp_checker u_checker (.*);

//--- bench/pmp_tb.sv
//--------------------------------------------------------------------------
// PMP checker testbench
// Directed and seeded random requests over TOR, NAPOT, overlap, lock and
// cross cases; the bound checker asserts every response
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module pmp_tb;

  localparam int STIM_CYCLES = 240;                // Reset plus all phases
  localparam int TIMEOUT     = STIM_CYCLES + 100;

  // Pages around the two TOR bounds
  localparam logic [27:0] TOR_PAGES [4] = '{28'h0ff, 28'h100, 28'h1ff, 28'h200};

  logic                clk = 1'b0;
  logic                rst_n;
  logic                cfg_wr;
  pmp_pkg::entry_idx_t cfg_idx;
  pmp_pkg::pmpcfg_t    cfg_data;
  pmp_pkg::pmpaddr_t   cfg_addr;
  logic                req_vld;
  pmp_pkg::ppn_t       req_ppn;
  logic                req_chk1;
  pmp_pkg::acc_type_e  req_acc;
  logic                req_mmode;
  logic                resp_vld, resp_fault, resp_hit, resp_cross;
  pmp_pkg::entry_idx_t resp_idx;
  int                  cycle_cnt = 0;

  always #2 clk = ~clk;                            // 4 ns period

  pmp_top u_pmp_top (.*);

  // One-cycle entry write strobe
  task automatic write_entry(input int idx, input logic [7:0] data, input logic [28:0] addr);
    cfg_wr   = 1'b1;
    cfg_idx  = idx[2:0];
    cfg_data = data;
    cfg_addr = addr;
    @(negedge clk);
    cfg_wr = 1'b0;
  endtask

  // Single request strobe
  task automatic send_req(input logic [27:0] ppn, input logic chk1, input int acc,
                          input logic mmode);
    req_vld   = 1'b1;
    req_ppn   = ppn;
    req_chk1  = chk1;
    req_mmode = mmode;
    req_acc   = pmp_pkg::acc_type_e'(acc[1:0]);
    @(negedge clk);
    req_vld = 1'b0;
  endtask

  // NAPOT pmpaddr for 2**k pages at an aligned base
  function automatic logic [28:0] napot_addr(input logic [27:0] base, input int k);
    if (k == 0)
      return {base, 1'b0};
    return {base | ((28'd1 << (k - 1)) - 28'd1), 1'b1};
  endfunction

  // First failed assertion ends the run
  always @(negedge clk)
    if (u_pmp_top.u_checker.err_cnt != 0)
    begin
      $display("Checks failed");
      $fatal(1, "An assertion in the checker failed");
    end

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT)
    begin
      $display("Run timed out after %0d cycles", cycle_cnt);
      $display("Checks failed");
      $fatal(1, "Timeout");
    end
  end

  initial
  begin
    logic [27:0] base;
    int          k;
    void'($urandom(32'hde32_1847));
    rst_n     = 1'b0;
    cfg_wr    = 1'b0;
    cfg_idx   = '0;
    cfg_data  = '0;
    cfg_addr  = '0;
    req_vld   = 1'b0;
    req_ppn   = '0;
    req_chk1  = 1'b0;
    req_acc   = pmp_pkg::ACC_READ;
    req_mmode = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);
    // All entries OFF
    for (int i = 0; i < 20; i++)
      send_req($urandom, $urandom, $urandom_range(2), i[0]);
    // TOR pair with entry 0 read only and entry 1 write and exec
    write_entry(0, 8'h09, {28'h100, 1'b0});
    write_entry(1, 8'h0e, {28'h200, 1'b0});
    for (int j = 0; j < 4; j++)
      for (int a = 0; a < 3; a++)
      begin
        send_req(TOR_PAGES[j], 1'b0, a, 1'b0);
        send_req(TOR_PAGES[j], 1'b1, a, 1'b1);
      end
    write_entry(0, 8'h00, '0);
    write_entry(1, 8'h00, '0);
    // NAPOT regions of random size hit on first and last page and just outside
    for (int n = 0; n < 16; n++)
    begin
      k = $urandom_range(20);
      base = $urandom & ~((28'd1 << k) - 28'd1);
      write_entry(2, 8'h18 | ($urandom & 8'h07), napot_addr(base, k));
      send_req(base, $urandom, $urandom_range(2), $urandom);
      send_req(base + (28'd1 << k) - 28'd1, $urandom, $urandom_range(2), $urandom);
      send_req(base - 28'd1, $urandom, $urandom_range(2), $urandom);
      send_req(base + (28'd1 << k), $urandom, $urandom_range(2), $urandom);
    end
    // Entry 4 with full access overlaps entry 5 with none
    write_entry(2, 8'h00, '0);
    write_entry(4, 8'h1f, napot_addr(28'h4000, 6));
    write_entry(5, 8'h18, napot_addr(28'h4000, 8));
    for (int n = 0; n < 6; n++)
    begin
      send_req(28'h4000 + $urandom_range(63), 1'b0, $urandom_range(2), 1'b0);
      send_req(28'h4040 + $urandom_range(191), 1'b0, $urandom_range(2), 1'b0);
    end
    // Cross flag around random NAPOT regions, entry 3 alone
    write_entry(4, 8'h00, '0);
    write_entry(5, 8'h00, '0);
    for (int n = 0; n < 20; n++)
    begin
      k = $urandom_range(12);
      base = $urandom & ~((28'd1 << k) - 28'd1);
      write_entry(3, 8'h18, napot_addr(base, k));
      send_req(base + $urandom_range((1 << k) + 8) - 28'd4, 1'b0, $urandom_range(2), 1'b0);
      send_req(base + $urandom_range((1 << k) + 8) - 28'd4, 1'b1, $urandom_range(2), 1'b1);
    end
    write_entry(3, 8'h00, '0);
    // Locked entry drops later writes and restricts M mode
    write_entry(6, 8'h99, napot_addr(28'h8000, 4));
    write_entry(6, 8'h1f, napot_addr(28'h8000, 4));
    write_entry(7, 8'h18, napot_addr(28'h9000, 4));
    send_req(28'h8003, 1'b0, 1, 1'b1);             // Write to locked read only
    send_req(28'h8003, 1'b0, 0, 1'b1);
    send_req(28'h800f, 1'b0, 2, 1'b1);
    send_req(28'h9001, 1'b0, 1, 1'b1);             // Unlocked entry leaves M mode free
    send_req(28'h9002, 1'b0, 2, 1'b1);
    send_req(28'h9002, 1'b0, 0, 1'b0);
    repeat (4) @(negedge clk);
    if (u_pmp_top.u_checker.err_cnt == 0)
    begin
      $display("All checks passed");
      $finish;
    end
    else
    begin
      $display("Checks failed");
      $fatal(1, "Checker reported errors");
    end
  end

endmodule

//--- filelist.f
+incdir+hdl
hdl/pmp_pkg.sv
hdl/pmp_entry_if.sv
hdl/pmp_cfg_regs.sv
hdl/pmp_comp_hit.sv
hdl/pmp_prio_resolve.sv
hdl/pmp_top.sv
bench/pmp_checker.sv
bench/pmp_tb.sv

//--- hdl/pmp_cfg_regs.sv
//--------------------------------------------------------------------------
// PMP configuration feeder
// Holds the cfg bytes and pmpaddr values of all entries, takes strobed
// writes, drops writes to locked entries and fans the fields out
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "pmp_consts.svh"

module pmp_cfg_regs (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cfg_wr,       // Single-cycle write strobe
  input  pmp_pkg::entry_idx_t  cfg_idx,
  input  pmp_pkg::pmpcfg_t     cfg_data,
  input  pmp_pkg::pmpaddr_t    cfg_addr,
  pmp_entry_if.feeder          ent [`PMP_ENTRIES-1:0]
);

  // Per-entry write enables after lock filtering
  logic [`PMP_ENTRIES-1:0] wr_en;

  //------------------------------------------------------------------------
  // One register pair per entry
  //------------------------------------------------------------------------
  for (genvar i = 0; i < `PMP_ENTRIES; i++)
  begin : g_reg
    pmp_pkg::pmpcfg_t  cfg_q;            // Bits 6..5 reserved, kept as written
    pmp_pkg::pmpaddr_t addr_q;

    // Strobe decode, lock blocks both cfg and address
    assign wr_en[i] = cfg_wr
                   && (cfg_idx == pmp_pkg::entry_idx_t'(i))
                   && !cfg_q[`PMP_CFG_L];

    always_ff @(posedge clk or negedge rst_n)
    begin
      if (!rst_n)
      begin
        cfg_q  <= '0;                    // OFF, unlocked, no permissions
        addr_q <= '0;
      end
      else if (wr_en[i])
      begin
        cfg_q  <= cfg_data;
        addr_q <= cfg_addr;
      end
    end

    // Field split towards the comparator and resolver
    assign ent[i].mode       = pmp_pkg::match_mode_e'(cfg_q[`PMP_CFG_A_HI:`PMP_CFG_A_LO]);
    assign ent[i].addr_value = addr_q;
    assign ent[i].perm_r     = cfg_q[`PMP_CFG_R];
    assign ent[i].perm_w     = cfg_q[`PMP_CFG_W];
    assign ent[i].perm_x     = cfg_q[`PMP_CFG_X];
    assign ent[i].locked     = cfg_q[`PMP_CFG_L];  // Also restricts M mode
  end

endmodule

//--- hdl/pmp_comp_hit.sv
//--------------------------------------------------------------------------
// PMP entry comparator
// TOR and NAPOT page match, the bottom flag for the next entry and the
// NAPOT boundary cross check, all combinational
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "pmp_consts.svh"

module pmp_comp_hit (
  pmp_entry_if.entry         ent,
  input  pmp_pkg::ppn_t      req_ppn,
  input  logic               req_chk1,     // Check against region end
  input  logic               ge_bottom,    // From the entry below
  output logic               ge_upaddr     // To the entry above
);

  localparam pmp_pkg::ppn_t MASK_ALL = '1;

  pmp_pkg::ppn_t              addr_base;    // pmpaddr without the NAPOT bit
  pmp_pkg::ppn_t              addr_mask;
  pmp_pkg::ppn_t              napot_begin;
  pmp_pkg::ppn_t              napot_end;
  pmp_pkg::ppn_t              napot_cmp;
  logic [`PMP_PPN_WIDTH:0]    comp_diff;    // Extra bit holds the borrow
  logic [`PMP_PPN_WIDTH:0]    napot_diff;
  logic                       ls_top;
  logic                       tor_match;
  logic                       napot_match;
  logic                       is_napot;
  logic                       hit_sel;

  assign addr_base = ent.addr_value[`PMP_ADDR_WIDTH-1:1];

  //------------------------------------------------------------------------
  // TOR compare, borrow means page below the top
  //------------------------------------------------------------------------
  assign comp_diff = {1'b0, req_ppn} - {1'b0, addr_base};
  assign ls_top    = comp_diff[`PMP_PPN_WIDTH];
  assign tor_match = ge_bottom && ls_top;
  assign ge_upaddr = !ls_top;
  assign ent.ge_upaddr = ge_upaddr;

  //------------------------------------------------------------------------
  // NAPOT size from the trailing ones of pmpaddr
  //------------------------------------------------------------------------
  always_comb
  begin
    priority casez (ent.addr_value)
      29'b????_????_????_????_????_????_????_0 : addr_mask = MASK_ALL;        // 4K
      29'b????_????_????_????_????_????_???0_1 : addr_mask = MASK_ALL << 1;
      29'b????_????_????_????_????_????_??01_1 : addr_mask = MASK_ALL << 2;
      29'b????_????_????_????_????_????_?011_1 : addr_mask = MASK_ALL << 3;
      29'b????_????_????_????_????_????_0111_1 : addr_mask = MASK_ALL << 4;   // 64K
      29'b????_????_????_????_????_???0_1111_1 : addr_mask = MASK_ALL << 5;
      29'b????_????_????_????_????_??01_1111_1 : addr_mask = MASK_ALL << 6;
      29'b????_????_????_????_????_?011_1111_1 : addr_mask = MASK_ALL << 7;
      29'b????_????_????_????_????_0111_1111_1 : addr_mask = MASK_ALL << 8;   // 1M
      29'b????_????_????_????_???0_1111_1111_1 : addr_mask = MASK_ALL << 9;
      29'b????_????_????_????_??01_1111_1111_1 : addr_mask = MASK_ALL << 10;
      29'b????_????_????_????_?011_1111_1111_1 : addr_mask = MASK_ALL << 11;
      29'b????_????_????_????_0111_1111_1111_1 : addr_mask = MASK_ALL << 12;  // 16M
      29'b????_????_????_???0_1111_1111_1111_1 : addr_mask = MASK_ALL << 13;
      29'b????_????_????_??01_1111_1111_1111_1 : addr_mask = MASK_ALL << 14;
      29'b????_????_????_?011_1111_1111_1111_1 : addr_mask = MASK_ALL << 15;
      29'b????_????_????_0111_1111_1111_1111_1 : addr_mask = MASK_ALL << 16;  // 256M
      29'b????_????_???0_1111_1111_1111_1111_1 : addr_mask = MASK_ALL << 17;
      29'b????_????_??01_1111_1111_1111_1111_1 : addr_mask = MASK_ALL << 18;  // 1G
      29'b????_????_?011_1111_1111_1111_1111_1 : addr_mask = MASK_ALL << 19;
      29'b????_????_0111_1111_1111_1111_1111_1 : addr_mask = MASK_ALL << 20;
      29'b????_???0_1111_1111_1111_1111_1111_1 : addr_mask = MASK_ALL << 21;
      29'b????_??01_1111_1111_1111_1111_1111_1 : addr_mask = MASK_ALL << 22;  // 16G
      29'b????_?011_1111_1111_1111_1111_1111_1 : addr_mask = MASK_ALL << 23;
      29'b????_0111_1111_1111_1111_1111_1111_1 : addr_mask = MASK_ALL << 24;
      29'b???0_1111_1111_1111_1111_1111_1111_1 : addr_mask = MASK_ALL << 25;
      29'b??01_1111_1111_1111_1111_1111_1111_1 : addr_mask = MASK_ALL << 26;  // 256G
      29'b?011_1111_1111_1111_1111_1111_1111_1 : addr_mask = MASK_ALL << 27;
      29'b0111_1111_1111_1111_1111_1111_1111_1 : addr_mask = '0;              // 1T
      default                                  : addr_mask = '0;              // All ones
    endcase
  end

  // Region bounds and match
  assign napot_begin = addr_base & addr_mask;
  assign napot_end   = addr_base | ~addr_mask;
  assign napot_match = (req_ppn & addr_mask) == napot_begin;

  //------------------------------------------------------------------------
  // Cross check, chk1 picks which bound is compared
  //------------------------------------------------------------------------
  assign is_napot   = (ent.mode == pmp_pkg::PMP_NAPOT);
  assign napot_cmp  = req_chk1 ? napot_end : napot_begin;
  assign napot_diff = {1'b0, req_ppn} - {1'b0, napot_cmp};
  assign ent.napot_cross = is_napot
                        && (req_chk1 ? napot_diff[`PMP_PPN_WIDTH]      // Below last page
                                     : !napot_diff[`PMP_PPN_WIDTH]);   // At or above first

  // Hit by mode
  always_comb
  begin
    case (ent.mode)
      pmp_pkg::PMP_TOR:   hit_sel = tor_match;
      pmp_pkg::PMP_NAPOT: hit_sel = napot_match;
      pmp_pkg::PMP_NA4:   hit_sel = 1'b0;      // Too fine for pages
      default:            hit_sel = 1'b0;      // OFF
    endcase
  end

  assign ent.hit = hit_sel;

endmodule

//--- hdl/pmp_consts.svh
//--------------------------------------------------------------------------
// PMP checker constants
// Address widths, entry count and cfg byte bit positions
//--------------------------------------------------------------------------
`ifndef PMP_CONSTS_SVH
`define PMP_CONSTS_SVH

// Address widths, page granular
`define PMP_PA_WIDTH    40          // Physical address
`define PMP_PPN_WIDTH   28          // 4 KB page number
`define PMP_ADDR_WIDTH  29          // pmpaddr, one extra NAPOT bit

// Entry table
`define PMP_ENTRIES     8
`define PMP_IDX_WIDTH   3

//--------------------------------------------------------------------------
// pmpcfg byte layout
//--------------------------------------------------------------------------
`define PMP_CFG_R       0           // Read permit
`define PMP_CFG_W       1           // Write permit
`define PMP_CFG_X       2           // Exec permit
`define PMP_CFG_A_LO    3           // Match mode, low bit
`define PMP_CFG_A_HI    4           // Match mode, high bit
`define PMP_CFG_L       7           // Lock

`endif

//--- hdl/pmp_entry_if.sv
//--------------------------------------------------------------------------
// PMP entry bundle
// Configuration of one entry going out from the feeder and the match
// results coming back from its comparator
//--------------------------------------------------------------------------
`timescale 1ns/10ps

interface pmp_entry_if;

  // Configuration, driven by the feeder
  pmp_pkg::match_mode_e mode;
  pmp_pkg::pmpaddr_t    addr_value;
  logic                 perm_r;
  logic                 perm_w;
  logic                 perm_x;
  logic                 locked;

  // Comparator results
  logic                 hit;
  logic                 ge_upaddr;     // Page at or above this entry's address
  logic                 napot_cross;   // NAPOT boundary crossed

  modport feeder (
    output mode, addr_value, perm_r, perm_w, perm_x, locked
  );

  modport entry (
    input  mode, addr_value,
    output hit, ge_upaddr, napot_cross
  );

  modport resolver (
    input  hit, napot_cross, perm_r, perm_w, perm_x, locked
  );

endinterface

//--- hdl/pmp_pkg.sv
//--------------------------------------------------------------------------
// PMP checker types
// Vector typedefs for pages, pmpaddr values, cfg bytes and entry numbers,
// plus the match mode and access type encodings
//--------------------------------------------------------------------------
`include "pmp_consts.svh"

package pmp_pkg;

  // Page number compared by every entry
  typedef logic [`PMP_PPN_WIDTH-1:0]  ppn_t;

  // pmpaddr value, bit 0 is the extra NAPOT size bit
  typedef logic [`PMP_ADDR_WIDTH-1:0] pmpaddr_t;

  // Raw cfg byte as written by software
  typedef logic [7:0]                 pmpcfg_t;

  // Entry number, also the response index
  typedef logic [`PMP_IDX_WIDTH-1:0]  entry_idx_t;

  //------------------------------------------------------------------------
  // Encodings
  //------------------------------------------------------------------------
  // Address match mode, same as the A field of pmpcfg
  typedef enum logic [1:0] {
    PMP_OFF   = 2'b00,              // Entry disabled
    PMP_TOR   = 2'b01,              // Top of range
    PMP_NA4   = 2'b10,              // Never hits at page granularity
    PMP_NAPOT = 2'b11               // Naturally aligned power of two
  } match_mode_e;

  // Access kind, selects the permission bit
  typedef enum logic [1:0] {
    ACC_READ  = 2'b00,
    ACC_WRITE = 2'b01,
    ACC_EXEC  = 2'b10
  } acc_type_e;

endpackage

//--- hdl/pmp_prio_resolve.sv
//--------------------------------------------------------------------------
// PMP priority resolver
// Lowest-index hit wins, permission and lock rule applied to the winner,
// response registered one cycle after the request strobe
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "pmp_consts.svh"

module pmp_prio_resolve (
  input  logic                 clk,
  input  logic                 rst_n,
  pmp_entry_if.resolver        ent [`PMP_ENTRIES-1:0],
  input  logic                 req_vld,
  input  pmp_pkg::acc_type_e   req_acc,
  input  logic                 req_mmode,    // 1 for M mode, 0 for U mode
  output logic                 resp_vld,
  output logic                 resp_fault,
  output logic                 resp_hit,
  output pmp_pkg::entry_idx_t  resp_idx,
  output logic                 resp_cross
);

  logic [`PMP_ENTRIES-1:0] hit_vec;
  logic [`PMP_ENTRIES-1:0] cross_vec;
  logic [`PMP_ENTRIES-1:0] r_vec;
  logic [`PMP_ENTRIES-1:0] w_vec;
  logic [`PMP_ENTRIES-1:0] x_vec;
  logic [`PMP_ENTRIES-1:0] lock_vec;
  pmp_pkg::entry_idx_t     win_idx;
  logic                    any_hit;
  logic                    perm_ok;
  logic                    fault_nxt;

  // Flatten the entry bundles into vectors
  for (genvar i = 0; i < `PMP_ENTRIES; i++)
  begin : g_gather
    assign hit_vec[i]   = ent[i].hit;
    assign cross_vec[i] = ent[i].napot_cross;
    assign r_vec[i]     = ent[i].perm_r;
    assign w_vec[i]     = ent[i].perm_w;
    assign x_vec[i]     = ent[i].perm_x;
    assign lock_vec[i]  = ent[i].locked;
  end

  //------------------------------------------------------------------------
  // Priority encoder, scan from the top so the lowest index is left
  //------------------------------------------------------------------------
  always_comb
  begin
    win_idx = '0;                          // 0 when nothing hits
    for (int i = `PMP_ENTRIES - 1; i >= 0; i--)
    begin
      if (hit_vec[i])
        win_idx = pmp_pkg::entry_idx_t'(i);
    end
  end

  assign any_hit = |hit_vec;

  // Permission bit of the winner for this access
  always_comb
  begin
    case (req_acc)
      pmp_pkg::ACC_READ:  perm_ok = r_vec[win_idx];
      pmp_pkg::ACC_WRITE: perm_ok = w_vec[win_idx];
      pmp_pkg::ACC_EXEC:  perm_ok = x_vec[win_idx];
      default:            perm_ok = 1'b0;
    endcase
  end

  // No hit: only M mode passes. Hit: U mode or locked entry checks perms
  assign fault_nxt = any_hit ? ((!req_mmode || lock_vec[win_idx]) && !perm_ok)
                             : !req_mmode;

  //------------------------------------------------------------------------
  // Response registers
  //------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      resp_vld <= 1'b0;
    else
      resp_vld <= req_vld;                 // One-cycle pulse per request
  end

  always_ff @(posedge clk)
  begin
    if (req_vld)
    begin
      resp_fault <= fault_nxt;
      resp_hit   <= any_hit;
      resp_idx   <= win_idx;
      resp_cross <= |cross_vec;            // Any NAPOT entry crossed
    end
  end

endmodule

//--- hdl/pmp_top.sv
//--------------------------------------------------------------------------
// PMP checker top level
// Configuration feeder, one comparator per entry chained by the bottom
// flags, and the priority resolver with its registered response
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "pmp_consts.svh"

module pmp_top (
  input  logic                 clk,
  input  logic                 rst_n,

  // Configuration write
  input  logic                 cfg_wr,
  input  pmp_pkg::entry_idx_t  cfg_idx,
  input  pmp_pkg::pmpcfg_t     cfg_data,
  input  pmp_pkg::pmpaddr_t    cfg_addr,

  // Check request
  input  logic                 req_vld,
  input  pmp_pkg::ppn_t        req_ppn,
  input  logic                 req_chk1,
  input  pmp_pkg::acc_type_e   req_acc,
  input  logic                 req_mmode,

  // Check response, one cycle later
  output logic                 resp_vld,
  output logic                 resp_fault,
  output logic                 resp_hit,
  output pmp_pkg::entry_idx_t  resp_idx,
  output logic                 resp_cross
);

  // Bit i feeds entry i, top bit is the last entry's flag
  logic [`PMP_ENTRIES:0] ge_chain;

  pmp_entry_if u_ent_if [`PMP_ENTRIES-1:0] ();

  assign ge_chain[0] = 1'b1;               // Every page is at or above zero

  //------------------------------------------------------------------------
  // Configuration feeder
  //------------------------------------------------------------------------
  pmp_cfg_regs u_cfg_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .cfg_wr   (cfg_wr),
    .cfg_idx  (cfg_idx),
    .cfg_data (cfg_data),
    .cfg_addr (cfg_addr),
    .ent      (u_ent_if)
  );

  //------------------------------------------------------------------------
  // Entry comparators
  //------------------------------------------------------------------------
  for (genvar i = 0; i < `PMP_ENTRIES; i++)
  begin : g_entry
    pmp_comp_hit u_comp (
      .ent       (u_ent_if[i]),
      .req_ppn   (req_ppn),
      .req_chk1  (req_chk1),
      .ge_bottom (ge_chain[i]),
      .ge_upaddr (ge_chain[i+1])
    );
  end

  // Resolver
  pmp_prio_resolve u_resolve (
    .clk        (clk),
    .rst_n      (rst_n),
    .ent        (u_ent_if),
    .req_vld    (req_vld),
    .req_acc    (req_acc),
    .req_mmode  (req_mmode),
    .resp_vld   (resp_vld),
    .resp_fault (resp_fault),
    .resp_hit   (resp_hit),
    .resp_idx   (resp_idx),
    .resp_cross (resp_cross)
  );

endmodule
